/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // port 0 is fetch and port 1 is load/store
    localparam int unsigned num_ports = 2;
    localparam int unsigned port_id_w = 1;

    // AXI id is wider than the port number so the upper bits stay zero
    localparam int unsigned axi_id_w = 4;

    localparam int unsigned addr_w = 32;
    localparam int unsigned data_w = 32;
    localparam int unsigned strb_w = data_w / 8;

    // anything but OKAY counts as an error
    localparam logic [1:0] axi_resp_okay = 2'b00;

    // single-word request from a port
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
        logic              we;
    } mem_req_t;

    // one-word response back to a port
    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              err;
    } mem_rsp_t;

    // request with the port that issued it
    typedef struct packed {
        logic [port_id_w-1:0] port;
        mem_req_t             req;
    } tagged_req_t;

endpackage

`default_nettype wire

/* hw/port_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module port_buffer import mem_pkg::*; (
    input  wire logic aclk,
    input  wire logic rst_n,
    input  wire mem_req_t req,
    input  wire logic req_valid,
    output logic req_ready,
    output mem_req_t buf_req,
    output logic buf_valid,
    input  wire logic buf_ready
);

    mem_req_t   mem_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       ready_en_q;
    logic       push;
    logic       pop;

    // held off for one cycle after reset
    assign req_ready = ready_en_q && (count_q != 2'd2);
    assign buf_valid = (count_q != 2'd0);
    assign buf_req   = mem_q[rd_ptr_q];

    assign push = req_valid && req_ready;
    assign pop  = buf_valid && buf_ready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
            count_q    <= 2'd0;
            ready_en_q <= 1'b0;
        end else begin
            ready_en_q <= 1'b1;
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req;
        end
    end

    // pointers meet only when empty or full
    a_ptr_count: assert property (
        @(posedge aclk) disable iff (!rst_n)
        count_q <= 2'd2 && ((wr_ptr_q != rd_ptr_q) == (count_q == 2'd1))
    );

    // head holds until the arbiter takes it
    a_head_stable: assert property (
        @(posedge aclk) disable iff (!rst_n)
        buf_valid && !buf_ready |=> buf_valid && $stable(buf_req)
    );

endmodule

`default_nettype wire

/* hw/req_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module req_arbiter import mem_pkg::*; (
    input  wire logic aclk,
    input  wire logic rst_n,
    input  wire mem_req_t buf_req [num_ports],
    input  wire logic [num_ports-1:0] buf_valid,
    output logic [num_ports-1:0] buf_ready,
    output tagged_req_t treq,
    output logic treq_valid,
    input  wire logic treq_ready
);

    logic [port_id_w-1:0] ptr_q;
    logic [port_id_w-1:0] lock_port_q;
    logic                 locked_q;
    logic [port_id_w-1:0] pick;
    logic                 found;
    logic [port_id_w-1:0] grant;

    // first valid port at or after the pointer
    always_comb begin
        int unsigned idx;
        found = 1'b0;
        pick  = ptr_q;
        for (int unsigned i = 0; i < num_ports; i++) begin
            idx = (int'(ptr_q) + i) % num_ports;
            if (!found && buf_valid[idx]) begin
                found = 1'b1;
                pick  = port_id_w'(idx);
            end
        end
    end

    assign grant      = locked_q ? lock_port_q : pick;
    assign treq_valid = locked_q ? buf_valid[lock_port_q] : found;
    assign treq.port  = grant;
    assign treq.req   = buf_req[grant];

    always_comb begin
        buf_ready = '0;
        buf_ready[grant] = treq_valid && treq_ready;
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            ptr_q       <= '0;
            lock_port_q <= '0;
            locked_q    <= 1'b0;
        end else if (treq_valid && treq_ready) begin
            locked_q <= 1'b0;
            // move priority past the winner
            if (grant == port_id_w'(num_ports - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= grant + 1'b1;
            end
        end else if (treq_valid) begin
            locked_q    <= 1'b1;
            lock_port_q <= grant;
        end
    end

    // a stalled offer keeps its port and payload
    a_grant_held: assert property (
        @(posedge aclk) disable iff (!rst_n)
        treq_valid && !treq_ready |=> treq_valid && $stable(treq)
    );

endmodule

`default_nettype wire

/* hw/axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_bridge import mem_pkg::*; (
    input  wire logic aclk,
    input  wire logic rst_n,
    input  wire tagged_req_t treq,
    input  wire logic treq_valid,
    output logic treq_ready,
    // read address
    output logic [axi_id_w-1:0] arid,
    output logic [addr_w-1:0] araddr,
    output logic arvalid,
    input  wire logic arready,
    // read data
    input  wire logic [axi_id_w-1:0] rid,
    input  wire logic [data_w-1:0] rdata,
    input  wire logic [1:0] rresp,
    input  wire logic rvalid,
    output logic rready,
    // write address
    output logic [axi_id_w-1:0] awid,
    output logic [addr_w-1:0] awaddr,
    output logic awvalid,
    input  wire logic awready,
    // write data
    output logic [data_w-1:0] wdata,
    output logic [strb_w-1:0] wstrb,
    output logic wvalid,
    input  wire logic wready,
    // write response
    input  wire logic [axi_id_w-1:0] bid,
    input  wire logic [1:0] bresp,
    input  wire logic bvalid,
    output logic bready,
    // responses to the ports
    output mem_rsp_t rsp [num_ports],
    output logic [num_ports-1:0] rsp_valid,
    input  wire logic [num_ports-1:0] rsp_ready
);

    typedef enum logic [2:0] {
        st_idle,
        st_ar,
        st_aw,
        st_r,
        st_b,
        st_ret
    } state_e;

    state_e               state_q;
    mem_req_t             req_q;
    logic [port_id_w-1:0] id_q;
    mem_rsp_t             rsp_q;
    logic                 aw_done_q;
    logic                 w_done_q;
    logic                 aw_done;
    logic                 w_done;

    assign treq_ready = (state_q == st_idle);

    assign arid    = axi_id_w'(id_q);
    assign araddr  = req_q.addr;
    assign arvalid = (state_q == st_ar);

    assign awid    = axi_id_w'(id_q);
    assign awaddr  = req_q.addr;
    assign awvalid = (state_q == st_aw) && !aw_done_q;
    assign wdata   = req_q.wdata;
    assign wstrb   = req_q.wstrb;
    assign wvalid  = (state_q == st_aw) && !w_done_q;

    // only take the AXI response once the port can take ours
    assign rready = (state_q == st_r) && rsp_ready[id_q];
    assign bready = (state_q == st_b) && rsp_ready[id_q];

    assign aw_done = aw_done_q || awready;
    assign w_done  = w_done_q || wready;

    always_comb begin
        for (int unsigned p = 0; p < num_ports; p++) begin
            rsp_valid[p] = (state_q == st_ret) && (id_q == port_id_w'(p));
            rsp[p]       = (id_q == port_id_w'(p)) ? rsp_q : '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    aw_done_q <= 1'b0;
                    w_done_q  <= 1'b0;
                    if (treq_valid) begin
                        state_q <= treq.req.we ? st_aw : st_ar;
                    end
                end
                st_ar: begin
                    if (arready) begin
                        state_q <= st_r;
                    end
                end
                st_aw: begin
                    // address and data may complete in either order
                    if (aw_done && w_done) begin
                        state_q <= st_b;
                    end else begin
                        aw_done_q <= aw_done;
                        w_done_q  <= w_done;
                    end
                end
                st_r: begin
                    if (rvalid && rready) begin
                        state_q <= st_ret;
                    end
                end
                st_b: begin
                    if (bvalid && bready) begin
                        state_q <= st_ret;
                    end
                end
                st_ret: begin
                    if (rsp_ready[id_q]) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (treq_valid && treq_ready) begin
            req_q <= treq.req;
            id_q  <= treq.port;
        end
        if (rvalid && rready) begin
            rsp_q.rdata <= rdata;
            rsp_q.err   <= (rresp != axi_resp_okay);
        end else if (bvalid && bready) begin
            rsp_q.rdata <= '0;
            rsp_q.err   <= (bresp != axi_resp_okay);
        end
    end

    // slave must answer with the id it was given
    a_rid_match: assert property (
        @(posedge aclk) disable iff (!rst_n)
        rvalid && rready |-> rid == axi_id_w'(id_q)
    );

    a_bid_match: assert property (
        @(posedge aclk) disable iff (!rst_n)
        bvalid && bready |-> bid == axi_id_w'(id_q)
    );

endmodule

`default_nettype wire

/* hw/mem_axi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_axi_top import mem_pkg::*; (
    input  wire logic aclk,
    input  wire logic rst_n,
    // requester ports
    input  wire mem_req_t req [num_ports],
    input  wire logic [num_ports-1:0] req_valid,
    output logic [num_ports-1:0] req_ready,
    output mem_rsp_t rsp [num_ports],
    output logic [num_ports-1:0] rsp_valid,
    input  wire logic [num_ports-1:0] rsp_ready,
    // AXI master
    output logic [axi_id_w-1:0] arid,
    output logic [addr_w-1:0] araddr,
    output logic arvalid,
    input  wire logic arready,
    input  wire logic [axi_id_w-1:0] rid,
    input  wire logic [data_w-1:0] rdata,
    input  wire logic [1:0] rresp,
    input  wire logic rvalid,
    output logic rready,
    output logic [axi_id_w-1:0] awid,
    output logic [addr_w-1:0] awaddr,
    output logic awvalid,
    input  wire logic awready,
    output logic [data_w-1:0] wdata,
    output logic [strb_w-1:0] wstrb,
    output logic wvalid,
    input  wire logic wready,
    input  wire logic [axi_id_w-1:0] bid,
    input  wire logic [1:0] bresp,
    input  wire logic bvalid,
    output logic bready
);

    mem_req_t             buf_req [num_ports];
    logic [num_ports-1:0] buf_valid;
    logic [num_ports-1:0] buf_ready;
    tagged_req_t          treq;
    logic                 treq_valid;
    logic                 treq_ready;

    // one request buffer per port
    for (genvar p = 0; p < num_ports; p++) begin : g_port
        port_buffer i_port_buffer (
            .aclk      (aclk),
            .rst_n     (rst_n),
            .req       (req[p]),
            .req_valid (req_valid[p]),
            .req_ready (req_ready[p]),
            .buf_req   (buf_req[p]),
            .buf_valid (buf_valid[p]),
            .buf_ready (buf_ready[p])
        );
    end

    req_arbiter i_req_arbiter (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .buf_req    (buf_req),
        .buf_valid  (buf_valid),
        .buf_ready  (buf_ready),
        .treq       (treq),
        .treq_valid (treq_valid),
        .treq_ready (treq_ready)
    );

    axi_bridge i_axi_bridge (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .treq       (treq),
        .treq_valid (treq_valid),
        .treq_ready (treq_ready),
        .arid       (arid),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .awid       (awid),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bid        (bid),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready)
    );

endmodule

`default_nettype wire

/* dv/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import mem_pkg::*; (
    input  wire logic aclk,
    input  wire logic rst_n,
    // response delay in cycles taken at each transfer
    input  wire logic [2:0] delay,
    input  wire logic [axi_id_w-1:0] arid,
    input  wire logic [addr_w-1:0] araddr,
    input  wire logic arvalid,
    output logic arready,
    output logic [axi_id_w-1:0] rid,
    output logic [data_w-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  wire logic rready,
    input  wire logic [axi_id_w-1:0] awid,
    input  wire logic [addr_w-1:0] awaddr,
    input  wire logic awvalid,
    output logic awready,
    input  wire logic [data_w-1:0] wdata,
    input  wire logic [strb_w-1:0] wstrb,
    input  wire logic wvalid,
    output logic wready,
    output logic [axi_id_w-1:0] bid,
    output logic [1:0] bresp,
    output logic bvalid,
    input  wire logic bready
);

    localparam int unsigned mem_words = 256;
    localparam int unsigned err_word = 240;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic [2:0] {
        st_idle,
        st_rd_wait,
        st_rd_rsp,
        st_wr_wait,
        st_wr_rsp
    } state_e;

    logic [data_w-1:0] mem [mem_words];
    state_e            state_q;
    logic [2:0]        cnt_q;
    logic              got_aw_q;
    logic              got_w_q;
    logic              ar_fire;
    logic              aw_fire;
    logic              w_fire;
    logic              r_fire;
    logic              b_fire;
    logic [7:0]        ar_word;
    logic [7:0]        aw_word;

    assign ar_word = araddr[9:2];
    assign aw_word = awaddr[9:2];

    // fill pattern covers every address bit of the word index
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (i * 32'h01010101) ^ 32'h5a3c0f96;
        end
    end

    // handshakes seen on the rising edge are acted on at the falling edge
    always @(posedge aclk) begin
        ar_fire <= arvalid && arready;
        aw_fire <= awvalid && awready;
        w_fire  <= wvalid && wready;
        r_fire  <= rvalid && rready;
        b_fire  <= bvalid && bready;
    end

    always @(negedge aclk) begin
        if (!rst_n) begin
            state_q  <= st_idle;
            cnt_q    <= '0;
            got_aw_q <= 1'b0;
            got_w_q  <= 1'b0;
            arready  <= 1'b1;
            awready  <= 1'b1;
            wready   <= 1'b1;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
            rid      <= '0;
            rdata    <= '0;
            rresp    <= 2'b00;
            bid      <= '0;
            bresp    <= 2'b00;
        end else begin
            case (state_q)
                st_idle: begin
                    if (ar_fire) begin
                        arready <= 1'b0;
                        awready <= 1'b0;
                        wready  <= 1'b0;
                        rid     <= arid;
                        rresp   <= (ar_word >= err_word) ? resp_slverr : 2'b00;
                        rdata   <= (ar_word >= err_word) ? '0 : mem[ar_word];
                        cnt_q   <= delay;
                        state_q <= st_rd_wait;
                    end else begin
                        if (aw_fire) begin
                            awready  <= 1'b0;
                            got_aw_q <= 1'b1;
                        end
                        if (w_fire) begin
                            wready  <= 1'b0;
                            got_w_q <= 1'b1;
                        end
                        if ((got_aw_q || aw_fire) && (got_w_q || w_fire)) begin
                            // error window keeps its contents
                            if (aw_word < err_word) begin
                                for (int b = 0; b < strb_w; b++) begin
                                    if (wstrb[b]) begin
                                        mem[aw_word][8*b +: 8] <= wdata[8*b +: 8];
                                    end
                                end
                            end
                            arready  <= 1'b0;
                            got_aw_q <= 1'b0;
                            got_w_q  <= 1'b0;
                            bid      <= awid;
                            bresp    <= (aw_word >= err_word) ? resp_slverr : 2'b00;
                            cnt_q    <= delay;
                            state_q  <= st_wr_wait;
                        end
                    end
                end
                st_rd_wait: begin
                    if (cnt_q == 3'd0) begin
                        rvalid  <= 1'b1;
                        state_q <= st_rd_rsp;
                    end else begin
                        cnt_q <= cnt_q - 3'd1;
                    end
                end
                st_wr_wait: begin
                    if (cnt_q == 3'd0) begin
                        bvalid  <= 1'b1;
                        state_q <= st_wr_rsp;
                    end else begin
                        cnt_q <= cnt_q - 3'd1;
                    end
                end
                default: begin
                    if ((state_q == st_rd_rsp && r_fire) ||
                        (state_q == st_wr_rsp && b_fire)) begin
                        rvalid  <= 1'b0;
                        bvalid  <= 1'b0;
                        arready <= 1'b1;
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        state_q <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* dv/tb_mem_axi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_axi_top import mem_pkg::*; ();

    localparam int unsigned mem_words = 256;
    localparam int unsigned err_word = 240;
    localparam int unsigned n_directed = 10;
    localparam int unsigned n_rand = 150;
    // each request normally finishes in about ten cycles
    localparam int unsigned cycle_limit = 40 * (n_directed + num_ports * n_rand);

    typedef struct packed {
        logic              rd;
        logic [data_w-1:0] data;
        logic              err;
    } exp_rsp_t;

    logic                 aclk;
    logic                 rst_n;
    mem_req_t             req [num_ports];
    logic [num_ports-1:0] req_valid;
    logic [num_ports-1:0] req_ready;
    mem_rsp_t             rsp [num_ports];
    logic [num_ports-1:0] rsp_valid;
    logic [num_ports-1:0] rsp_ready;
    logic [axi_id_w-1:0]  arid;
    logic [addr_w-1:0]    araddr;
    logic                 arvalid;
    logic                 arready;
    logic [axi_id_w-1:0]  rid;
    logic [data_w-1:0]    rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    logic                 rready;
    logic [axi_id_w-1:0]  awid;
    logic [addr_w-1:0]    awaddr;
    logic                 awvalid;
    logic                 awready;
    logic [data_w-1:0]    wdata;
    logic [strb_w-1:0]    wstrb;
    logic                 wvalid;
    logic                 wready;
    logic [axi_id_w-1:0]  bid;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 bready;
    logic [2:0]           mdl_delay;

    logic [31:0]       lfsr_q;
    logic [data_w-1:0] shadow [mem_words];
    mem_req_t          send_q [num_ports][$];
    mem_req_t          issued_q [num_ports][$];
    exp_rsp_t          exp_q [num_ports][$];
    int unsigned       drv_cnt [num_ports];
    int unsigned       acc_cnt [num_ports];
    int unsigned       rsp_cnt [num_ports];
    int unsigned       axi_port;
    int unsigned       errors;
    int unsigned       test_errs;
    int unsigned       tests_run;
    int unsigned       tests_failed;
    int unsigned       cycle_cnt;
    string             cur_test;

    mem_axi_top i_mem_axi_top (
        .aclk(aclk), .rst_n(rst_n),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .arid(arid), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rid(rid), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awid(awid), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

    axi_mem_model i_axi_mem_model (
        .aclk(aclk), .rst_n(rst_n), .delay(mdl_delay),
        .arid(arid), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rid(rid), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awid(awid), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic mem_req_t make_req(input logic we, input logic [7:0] word,
                                          input logic [data_w-1:0] data,
                                          input logic [strb_w-1:0] strb);
        mem_req_t r;
        r.addr  = {{(addr_w - 10){1'b0}}, word, 2'b00};
        r.wdata = data;
        r.wstrb = strb;
        r.we    = we;
        return r;
    endfunction

    function automatic mem_req_t rand_req();
        logic              we;
        logic [7:0]        word;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        we   = take_bits(1);
        word = take_bits(8);
        data = take_bits(32);
        strb = take_bits(4);
        return make_req(we, word, data, strb);
    endfunction

    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            count_error();
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, test_errs);
        end
    endtask

    // pair each bridge transfer with the port's oldest issued request
    task automatic take_axi(input logic [axi_id_w-1:0] id, input logic [addr_w-1:0] addr,
                            input logic we);
        mem_req_t    r;
        exp_rsp_t    e;
        int unsigned p;
        int unsigned w;
        p = id[port_id_w-1:0];
        check_val("axi id", p, id);
        axi_port = p;
        if (issued_q[p].size() == 0) begin
            $display("AXI transfer for port %0d with no request outstanding", p);
            count_error();
        end else begin
            r = issued_q[p].pop_front();
            check_val("axi addr", r.addr, addr);
            check_val("axi channel", r.we, we);
            if (we) begin
                check_val("axi wdata", r.wdata, wdata);
                check_val("axi wstrb", r.wstrb, wstrb);
            end
            w      = r.addr[9:2];
            e.rd   = !r.we;
            e.err  = (w >= err_word);
            e.data = '0;
            if (!e.err && r.we) begin
                for (int b = 0; b < strb_w; b++) begin
                    if (r.wstrb[b]) begin
                        shadow[w][8*b +: 8] = r.wdata[8*b +: 8];
                    end
                end
            end else if (!e.err) begin
                e.data = shadow[w];
            end
            exp_q[p].push_back(e);
        end
    endtask

    always @(posedge aclk) begin
        exp_rsp_t e;
        if (rst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                if (req_valid[p] && req_ready[p]) begin
                    issued_q[p].push_back(req[p]);
                    acc_cnt[p]++;
                end
                if (rsp_valid[p] && rsp_ready[p]) begin
                    rsp_cnt[p]++;
                    if (exp_q[p].size() == 0) begin
                        $display("port %0d returned a response nobody asked for", p);
                        count_error();
                    end else begin
                        e = exp_q[p].pop_front();
                        check_val("rsp err", e.err, rsp[p].err);
                        if (e.rd) begin
                            check_val("rsp rdata", e.data, rsp[p].rdata);
                        end
                    end
                end
            end
            if ((rready || bready) && !rsp_ready[axi_port]) begin
                $display("AXI response taken while port %0d holds rsp_ready low", axi_port);
                count_error();
            end
            if (arvalid && arready) begin
                take_axi(arid, araddr, 1'b0);
            end
            if (awvalid && awready) begin
                take_axi(awid, awaddr, 1'b1);
            end
        end
    end

    // sends both ports' queues and waits for every response
    task automatic drive_queues(input logic stall);
        int unsigned want [num_ports];
        logic        busy;
        for (int p = 0; p < num_ports; p++) begin
            want[p] = rsp_cnt[p] + send_q[p].size();
        end
        busy = 1'b1;
        while (busy) begin
            @(negedge aclk);
            busy = 1'b0;
            mdl_delay <= take_bits(3);
            for (int p = 0; p < num_ports; p++) begin
                if (!(req_valid[p] && acc_cnt[p] < drv_cnt[p])) begin
                    if (send_q[p].size() != 0 && (!stall || take_bits(1) == 1)) begin
                        req[p]       <= send_q[p].pop_front();
                        req_valid[p] <= 1'b1;
                        drv_cnt[p]++;
                    end else begin
                        req_valid[p] <= 1'b0;
                    end
                end
                rsp_ready[p] <= stall ? (take_bits(2) != 0) : 1'b1;
                if (rsp_cnt[p] != want[p]) begin
                    busy = 1'b1;
                end
            end
        end
        rsp_ready <= '1;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        lfsr_q    = 32'h2e9f;
        rst_n     = 1'b0;
        req_valid = '0;
        rsp_ready = '1;
        mdl_delay = '0;
        axi_port  = 0;
        errors    = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int p = 0; p < num_ports; p++) begin
            req[p]     = '0;
            drv_cnt[p] = 0;
            acc_cnt[p] = 0;
            rsp_cnt[p] = 0;
        end
        repeat (4) @(negedge aclk);

        begin_test("reset");
        check_val("rsp_valid", '0, rsp_valid);
        check_val("arvalid", 1'b0, arvalid);
        check_val("awvalid", 1'b0, awvalid);
        check_val("wvalid", 1'b0, wvalid);
        check_val("rready", 1'b0, rready);
        check_val("bready", 1'b0, bready);
        check_val("req_ready", '0, req_ready);
        rst_n <= 1'b1;
        end_test();
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = i_axi_mem_model.mem[i];
        end

        begin_test("write_read");
        send_q[0].push_back(make_req(1'b1, 8'd3, 32'hcafe0003, 4'hf));
        send_q[0].push_back(make_req(1'b0, 8'd3, '0, '0));
        send_q[1].push_back(make_req(1'b1, 8'd7, 32'h7eed0007, 4'hf));
        send_q[1].push_back(make_req(1'b0, 8'd7, '0, '0));
        drive_queues(1'b0);
        end_test();

        begin_test("strobe_merge");
        send_q[1].push_back(make_req(1'b1, 8'd10, 32'h11223344, 4'hf));
        send_q[1].push_back(make_req(1'b1, 8'd10, 32'haabbccdd, 4'b0101));
        send_q[1].push_back(make_req(1'b0, 8'd10, '0, '0));
        drive_queues(1'b0);
        end_test();

        begin_test("error_window");
        send_q[0].push_back(make_req(1'b1, 8'd245, 32'hdeadbeef, 4'hf));
        send_q[0].push_back(make_req(1'b0, 8'd245, '0, '0));
        send_q[1].push_back(make_req(1'b0, 8'd250, '0, '0));
        drive_queues(1'b0);
        end_test();

        begin_test("random_stream");
        for (int p = 0; p < num_ports; p++) begin
            for (int i = 0; i < n_rand; i++) begin
                send_q[p].push_back(rand_req());
            end
        end
        drive_queues(1'b1);
        end_test();

        begin_test("response_count");
        repeat (10) @(negedge aclk);
        for (int p = 0; p < num_ports; p++) begin
            check_val("responses", drv_cnt[p], rsp_cnt[p]);
            check_val("expected left", 0, exp_q[p].size());
        end
        end_test();

        $display("tests run %0d, tests failing %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_axi_top.f */
hw/mem_pkg.sv
hw/port_buffer.sv
hw/req_arbiter.sv
hw/axi_bridge.sv
hw/mem_axi_top.sv
dv/axi_mem_model.sv
dv/tb_mem_axi_top.sv

/* Bender.yml */
package:
  name: mem_axi_top

sources:
  - hw/mem_pkg.sv
  - hw/port_buffer.sv
  - hw/req_arbiter.sv
  - hw/axi_bridge.sv
  - hw/mem_axi_top.sv
  - target: test
    files:
      - dv/axi_mem_model.sv
      - dv/tb_mem_axi_top.sv
